// ==== hw/pci_master_pkg.sv ====
package pci_master_pkg;

   // Bus and data widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // 32-word burst buffer
   localparam int FIFO_AW = 5;

   // Burst length 1 to 32 needs six bits
   localparam int LEN_W = 6;

   // Core status vector
   localparam int CSR_W = 40;
   localparam int CSR_MABORT = 39;
   localparam int CSR_TABORT = 38;

   typedef enum logic [2:0] {
      ST_IDLE  = 3'd0,
      ST_REQ   = 3'd1,
      ST_READ  = 3'd2,
      ST_WRITE = 3'd3,
      ST_DEAD  = 3'd4,
      ST_DISC  = 3'd5
   } master_state_e;

   // PCI bus commands driven on m_cbe in the address phase
   typedef enum logic [3:0] {
      CMD_MEM_READ  = 4'd6,
      CMD_MEM_WRITE = 4'd7
   } pci_cmd_e;

endpackage

// ==== hw/master_fsm.sv ====
`timescale 1ns/1ps

module master_fsm (
   input  logic                                CLK,
   input  logic                                reset,
   input  logic                                cmd_req,
   input  logic                                cmd_dir,
   input  logic                                m_data,
   input  logic                                m_data_vld,
   input  logic                                m_src_en,
   input  logic [pci_master_pkg::CSR_W-1:0]    csr,
   input  logic                                last_beat,
   output logic                                cmd_ack,
   output logic                                sts_fatal,
   output logic                                start,
   output logic                                dir,
   output pci_master_pkg::master_state_e       state,
   output logic                                data_fell,
   output logic                                bus_push,
   output logic                                bus_pop,
   output logic                                request,
   output logic                                m_ready
);

   pci_master_pkg::master_state_e state_nxt;
   logic m_data_q;
   logic abort;
   logic burst_full;
   logic in_data;

   assign abort = csr[pci_master_pkg::CSR_MABORT] | csr[pci_master_pkg::CSR_TABORT];
   assign in_data = (state == pci_master_pkg::ST_READ) || (state == pci_master_pkg::ST_WRITE);

   // Accept a new command only once the previous ack is gone
   assign start = (state == pci_master_pkg::ST_IDLE) && cmd_req && !cmd_ack;

   // Falling edge of m_data ends the data phase
   assign data_fell = m_data_q & ~m_data;

   // Beats beyond the programmed length never reach the FIFO
   assign bus_push = (state == pci_master_pkg::ST_READ) && m_data_vld && !burst_full;
   assign bus_pop = (state == pci_master_pkg::ST_WRITE) && m_src_en && !burst_full;

   always_comb begin
      state_nxt = state;
      case (state)
         pci_master_pkg::ST_IDLE: begin
            if (start)
               state_nxt = pci_master_pkg::ST_REQ;
         end
         pci_master_pkg::ST_REQ: begin
            state_nxt = dir ? pci_master_pkg::ST_WRITE : pci_master_pkg::ST_READ;
         end
         pci_master_pkg::ST_READ, pci_master_pkg::ST_WRITE: begin
            if (data_fell)
               state_nxt = sts_fatal ? pci_master_pkg::ST_DEAD : pci_master_pkg::ST_DISC;
         end
         pci_master_pkg::ST_DEAD, pci_master_pkg::ST_DISC: begin
            // Leave once the user has seen the ack and released the request
            if (cmd_ack && !cmd_req)
               state_nxt = pci_master_pkg::ST_IDLE;
         end
         default: state_nxt = pci_master_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         state <= pci_master_pkg::ST_IDLE;
         m_data_q <= 1'b0;
         request <= 1'b0;
         m_ready <= 1'b0;
         dir <= 1'b0;
      end else begin
         state <= state_nxt;
         m_data_q <= m_data;
         request <= start;
         m_ready <= 1'b1;
         if (start)
            dir <= cmd_dir;
      end
   end

   // Abort seen at any point of the data phase is sticky until the next command
   always_ff @(posedge CLK or posedge reset) begin
      if (reset)
         sts_fatal <= 1'b0;
      else if (start)
         sts_fatal <= 1'b0;
      else if (m_data && abort)
         sts_fatal <= 1'b1;
   end

   always_ff @(posedge CLK or posedge reset) begin
      if (reset)
         burst_full <= 1'b0;
      else if (start)
         burst_full <= 1'b0;
      else if (in_data && m_data_vld && last_beat)
         burst_full <= 1'b1;
   end

   always_ff @(posedge CLK or posedge reset) begin
      if (reset)
         cmd_ack <= 1'b0;
      else if (!cmd_req)
         cmd_ack <= 1'b0;
      else if (state == pci_master_pkg::ST_DEAD || state == pci_master_pkg::ST_DISC)
         cmd_ack <= 1'b1;
   end

   a_request_in_req: assert property (@(posedge CLK) disable iff (reset)
      request |-> state == pci_master_pkg::ST_REQ);

   a_push_pop_excl: assert property (@(posedge CLK) disable iff (reset)
      !(bus_push && bus_pop));

endmodule

// ==== hw/beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter (
   input  logic                                CLK,
   input  logic                                reset,
   input  logic                                start,
   input  logic [pci_master_pkg::LEN_W-1:0]    cmd_len,
   input  logic                                m_data_vld,
   input  pci_master_pkg::master_state_e       state,
   output logic                                last_beat,
   output logic                                complete,
   output logic [pci_master_pkg::LEN_W-1:0]    sts_beats
);

   logic [pci_master_pkg::LEN_W-1:0] remaining;
   logic in_data;
   logic beat;

   assign in_data = (state == pci_master_pkg::ST_READ) || (state == pci_master_pkg::ST_WRITE);

   // A beat past the end of the burst is not counted
   assign beat = in_data && m_data_vld && (remaining != '0);

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         remaining <= '0;
         sts_beats <= '0;
      end else if (start) begin
         remaining <= cmd_len;
         sts_beats <= '0;
      end else if (beat) begin
         remaining <= remaining - 1'b1;
         sts_beats <= sts_beats + 1'b1;
      end
   end

   assign last_beat = (remaining == 1);

   // Early warning to the core, high through the final beat
   assign complete = in_data && (remaining <= 1);

   a_no_underflow: assert property (@(posedge CLK) disable iff (reset)
      (in_data && m_data_vld) |-> remaining != '0);

endmodule

// ==== hw/data_fifo.sv ====
`timescale 1ns/1ps

module data_fifo (
   input  logic                                CLK,
   input  logic                                reset,
   input  logic                                wr_req,
   input  logic [pci_master_pkg::DATA_W-1:0]   wr_data,
   input  logic                                rd_req,
   input  logic                                bus_push,
   input  logic [pci_master_pkg::DATA_W-1:0]   bus_data,
   input  logic                                bus_pop,
   output logic                                wr_ack,
   output logic                                rd_ack,
   output logic [pci_master_pkg::DATA_W-1:0]   rd_data,
   output logic [pci_master_pkg::DATA_W-1:0]   head_data
);

   localparam int DEPTH = 1 << pci_master_pkg::FIFO_AW;

   logic [pci_master_pkg::DATA_W-1:0] mem [DEPTH];
   logic [pci_master_pkg::FIFO_AW-1:0] wptr;
   logic [pci_master_pkg::FIFO_AW-1:0] rptr;
   logic [pci_master_pkg::FIFO_AW:0] count;
   logic full;
   logic empty;
   logic user_wr;
   logic user_rd;
   logic push;
   logic pop;
   logic [pci_master_pkg::DATA_W-1:0] push_data;

   assign full = (count == DEPTH);
   assign empty = (count == '0);

   // Bus side wins; the user handshake simply waits a cycle
   assign user_wr = wr_req && !wr_ack && !full && !bus_push;
   assign user_rd = rd_req && !rd_ack && !empty && !bus_pop;

   assign push = bus_push || user_wr;
   assign pop = bus_pop || user_rd;
   assign push_data = bus_push ? bus_data : wr_data;

   assign head_data = mem[rptr];

   always_ff @(posedge CLK) begin
      if (push)
         mem[wptr] <= push_data;
   end

   always_ff @(posedge CLK or posedge reset) begin
      if (reset) begin
         wptr <= '0;
         rptr <= '0;
         count <= '0;
      end else begin
         if (push)
            wptr <= wptr + 1'b1;
         if (pop)
            rptr <= rptr + 1'b1;
         case ({push, pop})
            2'b10: count <= count + 1'b1;
            2'b01: count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Four-phase load port
   always_ff @(posedge CLK or posedge reset) begin
      if (reset)
         wr_ack <= 1'b0;
      else if (!wr_req)
         wr_ack <= 1'b0;
      else if (user_wr)
         wr_ack <= 1'b1;
   end

   // Four-phase drain port
   always_ff @(posedge CLK or posedge reset) begin
      if (reset)
         rd_ack <= 1'b0;
      else if (!rd_req)
         rd_ack <= 1'b0;
      else if (user_rd)
         rd_ack <= 1'b1;
   end

   // Word stays put until the next drain
   always_ff @(posedge CLK) begin
      if (user_rd)
         rd_data <= mem[rptr];
   end

   a_no_push_full: assert property (@(posedge CLK) disable iff (reset)
      !(bus_push && full));

   a_no_pop_empty: assert property (@(posedge CLK) disable iff (reset)
      !(bus_pop && empty));

endmodule

// ==== hw/bus_driver.sv ====
`timescale 1ns/1ps

module bus_driver (
   input  logic                                CLK,
   input  logic                                reset,
   input  logic                                start,
   input  logic [pci_master_pkg::ADDR_W-1:0]   cmd_addr,
   input  logic                                dir,
   input  pci_master_pkg::master_state_e       state,
   input  logic                                m_addr_n,
   input  logic                                m_data,
   input  logic                                m_data_vld,
   input  logic [pci_master_pkg::DATA_W-1:0]   head_data,
   output logic [pci_master_pkg::DATA_W-1:0]   adio_in,
   output logic [$bits(pci_master_pkg::pci_cmd_e)-1:0] m_cbe,
   output logic                                m_wrdn
);

   // Word address, the low two bits are always zero on the bus
   logic [pci_master_pkg::ADDR_W-1:2] address;
   pci_master_pkg::pci_cmd_e command;
   logic in_data;
   logic drive_wdata;

   assign in_data = (state == pci_master_pkg::ST_READ) || (state == pci_master_pkg::ST_WRITE);
   assign drive_wdata = (state == pci_master_pkg::ST_WRITE) && m_data;

   always_ff @(posedge CLK or posedge reset) begin
      if (reset)
         address <= '0;
      else if (start)
         address <= cmd_addr[pci_master_pkg::ADDR_W-1:2];
      else if (in_data && m_data_vld)
         address <= address + 1'b1;
   end

   assign command = dir ? pci_master_pkg::CMD_MEM_WRITE : pci_master_pkg::CMD_MEM_READ;

   // All byte lanes enabled in the data phase
   assign m_cbe = !m_addr_n ? command : '0;
   assign m_wrdn = dir;

   always_comb begin
      if (!m_addr_n)
         adio_in = {address, 2'b00};
      else if (drive_wdata)
         adio_in = head_data;
      else
         adio_in = '0;
   end

endmodule

// ==== hw/pci_master.sv ====
`timescale 1ns/1ps

module pci_master (
   input  logic                                CLK,
   input  logic                                reset,
   input  logic                                cmd_req,
   input  logic                                cmd_dir,
   input  logic [pci_master_pkg::ADDR_W-1:0]   cmd_addr,
   input  logic [pci_master_pkg::LEN_W-1:0]    cmd_len,
   output logic                                cmd_ack,
   output logic                                sts_fatal,
   output logic [pci_master_pkg::LEN_W-1:0]    sts_beats,
   input  logic                                wr_req,
   input  logic [pci_master_pkg::DATA_W-1:0]   wr_data,
   output logic                                wr_ack,
   input  logic                                rd_req,
   output logic                                rd_ack,
   output logic [pci_master_pkg::DATA_W-1:0]   rd_data,
   input  logic [pci_master_pkg::DATA_W-1:0]   adio_out,
   input  logic                                m_data,
   input  logic                                m_data_vld,
   input  logic                                m_addr_n,
   input  logic                                m_src_en,
   input  logic [pci_master_pkg::CSR_W-1:0]    csr,
   output logic [pci_master_pkg::DATA_W-1:0]   adio_in,
   output logic [$bits(pci_master_pkg::pci_cmd_e)-1:0] m_cbe,
   output logic                                m_wrdn,
   output logic                                request,
   output logic                                complete,
   output logic                                m_ready
);

   logic start;
   logic dir;
   pci_master_pkg::master_state_e state;
   logic last_beat;
   logic bus_push;
   logic bus_pop;
   logic [pci_master_pkg::DATA_W-1:0] head_data;

   master_fsm master_fsm_inst (
      .CLK        (CLK),
      .reset      (reset),
      .cmd_req    (cmd_req),
      .cmd_dir    (cmd_dir),
      .m_data     (m_data),
      .m_data_vld (m_data_vld),
      .m_src_en   (m_src_en),
      .csr        (csr),
      .last_beat  (last_beat),
      .cmd_ack    (cmd_ack),
      .sts_fatal  (sts_fatal),
      .start      (start),
      .dir        (dir),
      .state      (state),
      .data_fell  (),
      .bus_push   (bus_push),
      .bus_pop    (bus_pop),
      .request    (request),
      .m_ready    (m_ready)
   );

   beat_counter beat_counter_inst (
      .CLK        (CLK),
      .reset      (reset),
      .start      (start),
      .cmd_len    (cmd_len),
      .m_data_vld (m_data_vld),
      .state      (state),
      .last_beat  (last_beat),
      .complete   (complete),
      .sts_beats  (sts_beats)
   );

   // Read data comes straight off the core's adio_out
   data_fifo data_fifo_inst (
      .CLK        (CLK),
      .reset      (reset),
      .wr_req     (wr_req),
      .wr_data    (wr_data),
      .rd_req     (rd_req),
      .bus_push   (bus_push),
      .bus_data   (adio_out),
      .bus_pop    (bus_pop),
      .wr_ack     (wr_ack),
      .rd_ack     (rd_ack),
      .rd_data    (rd_data),
      .head_data  (head_data)
   );

   bus_driver bus_driver_inst (
      .CLK        (CLK),
      .reset      (reset),
      .start      (start),
      .cmd_addr   (cmd_addr),
      .dir        (dir),
      .state      (state),
      .m_addr_n   (m_addr_n),
      .m_data     (m_data),
      .m_data_vld (m_data_vld),
      .head_data  (head_data),
      .adio_in    (adio_in),
      .m_cbe      (m_cbe),
      .m_wrdn     (m_wrdn)
   );

endmodule

// ==== tb/tb_pci_master.sv ====
`timescale 1ns/1ps

module tb_pci_master;

   localparam int MAX_TESTS = 32;
   localparam int COLS = 8;
   localparam int RESET_CYCLES = 10;

   logic        CLK;
   logic        reset;
   logic        cmd_req;
   logic        cmd_dir;
   logic [31:0] cmd_addr;
   logic [5:0]  cmd_len;
   logic        cmd_ack;
   logic        sts_fatal;
   logic [5:0]  sts_beats;
   logic        wr_req;
   logic [31:0] wr_data;
   logic        wr_ack;
   logic        rd_req;
   logic        rd_ack;
   logic [31:0] rd_data;
   logic [31:0] adio_out;
   logic        m_data;
   logic        m_data_vld;
   logic        m_addr_n;
   logic        m_src_en;
   logic [39:0] csr;
   logic [31:0] adio_in;
   logic [3:0]  m_cbe;
   logic        m_wrdn;
   logic        request;
   logic        complete;
   logic        m_ready;

   // Columns per line: kind dir addr len beats_given seed exp_fatal exp_beats
   logic [31:0] stim [0:MAX_TESTS*COLS-1];
   logic [31:0] words [0:31];
   logic [31:0] lcg_state;
   int cycles = 0;
   int cycle_limit = 1000000;
   int req_count = 0;
   int test_errors;
   int passed;
   int failed;
   int num_tests;
   string test_name;

   pci_master pci_master_inst (
      .CLK(CLK), .reset(reset),
      .cmd_req(cmd_req), .cmd_dir(cmd_dir), .cmd_addr(cmd_addr), .cmd_len(cmd_len),
      .cmd_ack(cmd_ack), .sts_fatal(sts_fatal), .sts_beats(sts_beats),
      .wr_req(wr_req), .wr_data(wr_data), .wr_ack(wr_ack),
      .rd_req(rd_req), .rd_ack(rd_ack), .rd_data(rd_data),
      .adio_out(adio_out), .m_data(m_data), .m_data_vld(m_data_vld),
      .m_addr_n(m_addr_n), .m_src_en(m_src_en), .csr(csr),
      .adio_in(adio_in), .m_cbe(m_cbe), .m_wrdn(m_wrdn),
      .request(request), .complete(complete), .m_ready(m_ready)
   );

   initial begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   always @(posedge CLK) begin
      cycles = cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped answering a handshake", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   always @(negedge CLK) begin
      if (request)
         req_count = req_count + 1;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp, act);
         test_errors++;
      end
   endtask

   task automatic record_result();
      if (test_errors == 0) begin
         passed++;
         $display("PASS %s", test_name);
      end else begin
         failed++;
         $display("FAIL %s with %0d errors", test_name, test_errors);
      end
   endtask

   task automatic load_word(input logic [31:0] w);
      @(posedge CLK);
      wr_req <= 1'b1;
      wr_data <= w;
      @(negedge CLK);
      while (!wr_ack) @(negedge CLK);
      @(posedge CLK);
      wr_req <= 1'b0;
      @(negedge CLK);
      while (wr_ack) @(negedge CLK);
   endtask

   task automatic drain_word(output logic [31:0] w);
      @(posedge CLK);
      rd_req <= 1'b1;
      @(negedge CLK);
      while (!rd_ack) @(negedge CLK);
      w = rd_data;
      @(posedge CLK);
      rd_req <= 1'b0;
      @(negedge CLK);
      while (rd_ack) @(negedge CLK);
   endtask

   // Core responder with address phase, the given beats and the drop of m_data
   task automatic run_burst(input logic d, input logic [31:0] addr, input int len,
                            input int given, input logic fatal);
      @(posedge CLK);
      cmd_dir <= d;
      cmd_addr <= addr;
      cmd_len <= len[5:0];
      cmd_req <= 1'b1;
      @(negedge CLK);
      while (!request) @(negedge CLK);
      @(posedge CLK);
      m_addr_n <= 1'b0;
      @(negedge CLK);
      check_value("address", addr & ~32'h3, adio_in);
      check_value("command", d ? 32'd7 : 32'd6, {28'd0, m_cbe});
      for (int i = 0; i < given; i++) begin
         @(posedge CLK);
         m_addr_n <= 1'b1;
         m_data <= 1'b1;
         m_data_vld <= 1'b1;
         m_src_en <= d;
         adio_out <= d ? 32'd0 : words[i];
         csr <= '0;
         // Master abort on writes, target abort on reads
         if (fatal && i == given - 1)
            csr[d ? 39 : 38] <= 1'b1;
         @(negedge CLK);
         if (d)
            check_value("write data", words[i], adio_in);
         check_value("m_wrdn", {31'd0, d}, {31'd0, m_wrdn});
         if (given == len && i == len - 1)
            check_value("complete last", 32'd1, {31'd0, complete});
         else if (given == len && i == 0)
            check_value("complete first", 32'd0, {31'd0, complete});
      end
      @(posedge CLK);
      m_data <= 1'b0;
      m_data_vld <= 1'b0;
      m_src_en <= 1'b0;
      adio_out <= '0;
      csr <= '0;
   endtask

   initial begin
      logic [31:0] kind;
      logic [31:0] got;
      logic d;
      int len;
      int given;
      string kind_name;
      reset = 1'b1;
      cmd_req = 1'b0;
      cmd_dir = 1'b0;
      cmd_addr = '0;
      cmd_len = '0;
      wr_req = 1'b0;
      wr_data = '0;
      rd_req = 1'b0;
      adio_out = '0;
      m_data = 1'b0;
      m_data_vld = 1'b0;
      m_addr_n = 1'b1;
      m_src_en = 1'b0;
      csr = '0;
      passed = 0;
      failed = 0;
      for (int i = 0; i < MAX_TESTS * COLS; i++)
         stim[i] = 32'hFFFF_FFFF;
      $readmemh("tb/stim_pci_master.txt", stim);
      num_tests = 0;
      while (num_tests < MAX_TESTS && stim[num_tests * COLS] != 32'hFFFF_FFFF)
         num_tests++;
      cycle_limit = RESET_CYCLES + 200 * num_tests;
      test_name = "reset";
      test_errors = 0;
      repeat (RESET_CYCLES) @(posedge CLK);
      reset <= 1'b0;
      @(negedge CLK);
      // Idle outputs right after reset and m_ready one cycle later
      check_value("request", 32'd0, {31'd0, request});
      check_value("cmd_ack", 32'd0, {31'd0, cmd_ack});
      check_value("wr_ack", 32'd0, {31'd0, wr_ack});
      check_value("rd_ack", 32'd0, {31'd0, rd_ack});
      check_value("complete", 32'd0, {31'd0, complete});
      check_value("m_ready low", 32'd0, {31'd0, m_ready});
      @(negedge CLK);
      check_value("m_ready high", 32'd1, {31'd0, m_ready});
      record_result();

      for (int t = 0; t < num_tests; t++) begin
         kind = stim[t * COLS];
         d = stim[t * COLS + 1][0];
         len = stim[t * COLS + 3];
         given = stim[t * COLS + 4];
         kind_name = (kind == 1) ? "fatal" : (kind == 2) ? "disconnect" : "full";
         test_name = $sformatf("test%0d_%s_%s", t, kind_name, d ? "write" : "read");
         test_errors = 0;
         req_count = 0;
         lcg_state = 32'h1092 ^ stim[t * COLS + 5];
         for (int i = 0; i < len; i++) begin
            lcg_state = lcg_next(lcg_state);
            words[i] = lcg_state;
         end
         if (d)
            for (int i = 0; i < len; i++)
               load_word(words[i]);
         run_burst(d, stim[t * COLS + 2], len, given, kind == 1);
         @(negedge CLK);
         while (!cmd_ack) @(negedge CLK);
         check_value("sts_fatal", stim[t * COLS + 6], {31'd0, sts_fatal});
         check_value("sts_beats", stim[t * COLS + 7], {26'd0, sts_beats});
         @(posedge CLK);
         cmd_req <= 1'b0;
         @(negedge CLK);
         while (cmd_ack) @(negedge CLK);
         check_value("request cycles", 32'd1, req_count);
         // Read data comes back in order and unsent write words get flushed
         if (!d) begin
            for (int i = 0; i < given; i++) begin
               drain_word(got);
               check_value("read data", words[i], got);
            end
         end else begin
            for (int i = given; i < len; i++) begin
               drain_word(got);
               check_value("leftover word", words[i], got);
            end
         end
         record_result();
      end

      $display("Tests run %0d, passed %0d, failed %0d", passed + failed, passed, failed);
      if (failed == 0 && num_tests > 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== tb/stim_pci_master.txt ====
// kind (0 full, 1 fatal, 2 disconnect) dir (1 write) addr len beats_given seed
// exp_fatal exp_beats, all hex
0 1 00001000 08 08 11 0 08
0 0 00002004 08 08 22 0 08
0 1 00003000 01 01 33 0 01
0 0 00003100 01 01 44 0 01
1 1 00004000 06 03 55 1 03
0 1 00004100 04 04 66 0 04
1 0 00005000 08 05 77 1 05
0 0 00005100 03 03 88 0 03
2 1 00006000 0A 04 99 0 04
2 0 00007000 10 07 AA 0 07
0 1 00008000 20 20 BB 0 20
0 0 00009000 20 20 CC 0 20

// ==== sources.f ====
hw/pci_master_pkg.sv
hw/master_fsm.sv
hw/beat_counter.sv
hw/data_fifo.sv
hw/bus_driver.sv
hw/pci_master.sv
tb/tb_pci_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log for failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pci_master \
   -f sources.f -o sim_tb > build.log 2>&1 \
   || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log

grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
